//--- hdl/lane_pkg.sv
//////////////////////////////////////////////////
// Lane side types for the vector lane array.
// Covers data and register index widths, the lane
// opcode set and the command and result words that
// pass between the issue unit, lanes and collector.
//////////////////////////////////////////////////

package lane_pkg;

	// Lane data word
	typedef logic [31:0] data_t;

	// Register index, bit 0 picks the bank
	typedef logic [3:0] reg_idx_t;

	// Row inside one bank
	typedef logic [2:0] bank_idx_t;

	// Immediate as carried in the command
	typedef logic [15:0] imm_t;

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_LDI  = 4'h6,		// dst = imm
		OP_LID  = 4'h7,		// dst = imm + lane number
		OP_SETM = 4'h8,		// mask = src1 < src2, unsigned
		OP_CLRM = 4'h9,		// mask = 1
		OP_READ = 4'ha		// host readback of src1, no write
	} lane_op_e;

	// Broadcast command, one per accepted access
	typedef struct packed {
		logic		valid;
		lane_op_e	op;
		reg_idx_t	dst;
		reg_idx_t	src1;
		reg_idx_t	src2;
		imm_t		imm;
	} lane_cmd_t;

	typedef struct packed {
		logic	done;
		data_t	data;
	} lane_result_t;

endpackage

//--- hdl/bus_pkg.sv
//////////////////////////////////////////////////
// Wishbone side definitions for the host port.
// Holds bus widths, the master request bundle,
// the address map and the command word layout.
//////////////////////////////////////////////////

package bus_pkg;

	typedef logic [11:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;

	// Master to slave signals
	typedef struct packed {
		logic		cyc;
		logic		stb;
		logic		we;
		wb_adr_t	adr;
		wb_dat_t	dat_w;
	} wb_req_t;

	////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////

	localparam wb_adr_t ADR_CMD         = 12'h000;
	localparam wb_adr_t ADR_REG_BASE    = 12'h100;
	localparam wb_adr_t REG_REGION_MASK = 12'hf00;

	// Register region address, lane in 7:4 and register in 3:0
	typedef struct packed {
		logic [3:0]	region;
		logic [3:0]	lane;
		logic [3:0]	idx;
	} reg_adr_t;

	// Command word written to ADR_CMD
	typedef struct packed {
		logic [3:0]		op;
		logic [3:0]		dst;
		logic [3:0]		src1;
		logic [3:0]		src2;
		logic [15:0]	imm;
	} cmd_word_t;

endpackage

//--- hdl/command_issue.sv
//////////////////////////////////////////////////
// Wishbone classic slave front end. Accepts one
// access at a time, decodes it into a lane command
// and broadcasts that command to every lane.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module command_issue
	import lane_pkg::*;
	import bus_pkg::*;
#(
	parameter int NUM_LANES = 4
)(
	input	logic							clock,
	input	logic							reset,
	input	wb_req_t						wb_req,
	input	logic							ack,
	output	lane_cmd_t						cmd,
	output	logic [$clog2(NUM_LANES)-1:0]	rd_lane
);

	localparam int LANE_W = $clog2(NUM_LANES);

	logic				busy;
	logic				accept;
	logic				is_cmd_wr;
	logic				is_reg_rd;
	cmd_word_t			word;
	reg_adr_t			reg_adr;
	lane_cmd_t			next_cmd;
	logic [LANE_W-1:0]	next_lane;

	// Master holds cyc/stb until ack, busy keeps us from taking it twice
	assign accept = wb_req.cyc & wb_req.stb & ~busy;

	assign word    = wb_req.dat_w;
	assign reg_adr = wb_req.adr;

	assign is_cmd_wr = wb_req.we && (wb_req.adr == ADR_CMD);
	assign is_reg_rd = !wb_req.we && ((wb_req.adr & REG_REGION_MASK) == ADR_REG_BASE);

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	always_comb begin
		next_cmd       = '0;
		next_cmd.valid = 1'b1;
		next_cmd.op    = OP_NOP;
		next_lane      = '0;

		if (is_cmd_wr) begin
			next_cmd.op   = lane_op_e'(word.op);
			next_cmd.dst  = word.dst;
			next_cmd.src1 = word.src1;
			next_cmd.src2 = word.src2;
			next_cmd.imm  = word.imm;
		end else if (is_reg_rd) begin
			// Readback rides the lane pipeline as a read of src1
			next_cmd.op   = OP_READ;
			next_cmd.src1 = reg_adr.idx;
			// Lane field wraps onto the lanes that exist
			next_lane     = LANE_W'(int'(reg_adr.lane) % NUM_LANES);
		end
		// Anything else becomes a NOP so the master still gets its ack
	end

	//////////////////////////////////////////////////
	// Capture
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			cmd     <= '0;
			rd_lane <= '0;
		end else begin
			if (accept) begin
				busy    <= 1'b1;
				cmd     <= next_cmd;
				rd_lane <= next_lane;
			end else begin
				// Command is only valid for one cycle
				cmd.valid <= 1'b0;
				if (ack) begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

//--- hdl/lane_regfile.sv
//////////////////////////////////////////////////
// Per-lane register file, 16 entries split into an
// even and an odd bank by index bit 0. Two read
// ports with one cycle latency, one write port.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_regfile
	import lane_pkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		we,
	input	reg_idx_t	wr_idx,
	input	data_t		wr_data,
	input	reg_idx_t	rd_idx1,
	input	reg_idx_t	rd_idx2,
	output	data_t		rd_data1,
	output	data_t		rd_data2
);

	bank_idx_t	wr_row;
	bank_idx_t	rd_row1;
	bank_idx_t	rd_row2;
	logic		sel1_q;
	logic		sel2_q;
	data_t		bank_rd1 [2];
	data_t		bank_rd2 [2];

	assign wr_row  = wr_idx[3:1];
	assign rd_row1 = rd_idx1[3:1];
	assign rd_row2 = rd_idx2[3:1];

	// Bank 0 holds even registers, bank 1 odd
	for (genvar b = 0; b < 2; b++) begin : g_bank
		data_t	mem [8];
		data_t	rd1_q;
		data_t	rd2_q;

		always_ff @(posedge clock) begin
			if (reset) begin
				for (int r = 0; r < 8; r++) begin
					mem[r] <= '0;
				end
			end else if (we && (wr_idx[0] == 1'(b))) begin
				mem[wr_row] <= wr_data;
			end
		end

		// Both banks read every cycle, the bank bit picks afterwards
		always_ff @(posedge clock) begin
			rd1_q <= mem[rd_row1];
			rd2_q <= mem[rd_row2];
		end

		assign bank_rd1[b] = rd1_q;
		assign bank_rd2[b] = rd2_q;
	end

	always_ff @(posedge clock) begin
		sel1_q <= rd_idx1[0];
		sel2_q <= rd_idx2[0];
	end

	assign rd_data1 = bank_rd1[sel1_q];
	assign rd_data2 = bank_rd2[sel2_q];

endmodule

//--- hdl/lane_unit.sv
//////////////////////////////////////////////////
// One SIMT lane. Reads its sources, runs the ALU,
// writes back under the lane mask and reports a
// result for every broadcast command.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_unit
	import lane_pkg::*;
#(
	parameter int LANE_ID = 0
)(
	input	logic			clock,
	input	logic			reset,
	input	lane_cmd_t		cmd,
	output	lane_result_t	result
);

	lane_cmd_t	rd_cmd;
	data_t		src1_data;
	data_t		src2_data;
	data_t		imm_ext;
	data_t		alu_out;
	logic		writes_reg;
	logic		src_lt;
	logic		mask;
	logic		wb_we;

	//////////////////////////////////////////////////
	// Read stage
	//////////////////////////////////////////////////

	lane_regfile u_regfile (
		.clock		(clock),
		.reset		(reset),
		.we			(wb_we),
		.wr_idx		(rd_cmd.dst),
		.wr_data	(alu_out),
		.rd_idx1	(cmd.src1),
		.rd_idx2	(cmd.src2),
		.rd_data1	(src1_data),
		.rd_data2	(src2_data)
	);

	// Command travels alongside the register read
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_cmd <= '0;
		end else begin
			rd_cmd <= cmd;
		end
	end

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////

	assign imm_ext = data_t'(rd_cmd.imm);
	assign src_lt  = src1_data < src2_data;

	always_comb begin
		alu_out    = '0;
		writes_reg = 1'b0;
		case (rd_cmd.op)
			OP_ADD: begin
				alu_out    = src1_data + src2_data;
				writes_reg = 1'b1;
			end
			OP_SUB: begin
				alu_out    = src1_data - src2_data;
				writes_reg = 1'b1;
			end
			OP_AND: begin
				alu_out    = src1_data & src2_data;
				writes_reg = 1'b1;
			end
			OP_OR: begin
				alu_out    = src1_data | src2_data;
				writes_reg = 1'b1;
			end
			OP_XOR: begin
				alu_out    = src1_data ^ src2_data;
				writes_reg = 1'b1;
			end
			OP_LDI: begin
				alu_out    = imm_ext;
				writes_reg = 1'b1;
			end
			// Lane identity
			OP_LID: begin
				alu_out    = imm_ext + data_t'(LANE_ID);
				writes_reg = 1'b1;
			end
			OP_SETM: alu_out = data_t'(src_lt);
			OP_CLRM: alu_out = data_t'(1'b1);
			OP_READ: alu_out = src1_data;
			default: alu_out = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Write-back
	//////////////////////////////////////////////////

	// Masked-off lanes keep their registers
	assign wb_we = rd_cmd.valid & writes_reg & mask;

	// Mask ops apply in every lane, masked or not
	always_ff @(posedge clock) begin
		if (reset) begin
			mask <= 1'b1;
		end else if (rd_cmd.valid && rd_cmd.op == OP_SETM) begin
			mask <= src_lt;
		end else if (rd_cmd.valid && rd_cmd.op == OP_CLRM) begin
			mask <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			result <= '0;
		end else begin
			result.done <= rd_cmd.valid;
			result.data <= alu_out;
		end
	end

endmodule

//--- hdl/commit_collect.sv
//////////////////////////////////////////////////
// Commit stage. Waits for every lane to report,
// then raises the Wishbone ack for one cycle with
// the readback word of the addressed lane.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module commit_collect
	import lane_pkg::*;
	import bus_pkg::*;
#(
	parameter int NUM_LANES = 4
)(
	input	logic							clock,
	input	logic							reset,
	input	lane_result_t					results [NUM_LANES],
	input	logic [$clog2(NUM_LANES)-1:0]	rd_lane,
	output	logic							ack,
	output	wb_dat_t						dat_r
);

	logic [NUM_LANES-1:0]	done_vec;
	lane_result_t			sel_result;

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			done_vec[i] = results[i].done;
		end
	end

	// Lane picked by the read address
	assign sel_result = results[rd_lane];

	// All lanes run in lockstep, so done flags line up
	always_ff @(posedge clock) begin
		if (reset) begin
			ack <= 1'b0;
		end else begin
			ack <= &done_vec;
		end
	end

	always_ff @(posedge clock) begin
		if (sel_result.done) begin
			dat_r <= sel_result.data;
		end else begin
			dat_r <= '0;
		end
	end

endmodule

//--- hdl/vector_lanes_top.sv
//////////////////////////////////////////////////
// Top of the vector lane array. Host talks to it
// over a Wishbone classic slave port; NUM_LANES
// sets the number of lanes built.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vector_lanes_top
	import lane_pkg::*;
	import bus_pkg::*;
#(
	parameter int NUM_LANES = 4
)(
	input	logic		clock,
	input	logic		reset,
	input	wb_req_t	wb_req,
	output	logic		ack,
	output	wb_dat_t	dat_r
);

	lane_cmd_t						cmd;
	lane_result_t					results [NUM_LANES];
	logic [$clog2(NUM_LANES)-1:0]	rd_lane;

	command_issue #(
		.NUM_LANES	(NUM_LANES)
	) u_issue (
		.clock		(clock),
		.reset		(reset),
		.wb_req		(wb_req),
		.ack		(ack),
		.cmd		(cmd),
		.rd_lane	(rd_lane)
	);

	// Every lane sees the same command
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_unit #(
			.LANE_ID	(i)
		) u_lane (
			.clock		(clock),
			.reset		(reset),
			.cmd		(cmd),
			.result		(results[i])
		);
	end

	commit_collect #(
		.NUM_LANES	(NUM_LANES)
	) u_collect (
		.clock		(clock),
		.reset		(reset),
		.results	(results),
		.rd_lane	(rd_lane),
		.ack		(ack),
		.dat_r		(dat_r)
	);

endmodule

//--- tests/tb_vector_lanes.sv
//////////////////////////////////////////////////
// Testbench for the vector lane array. Acts as a
// Wishbone master, keeps a model of every lane's
// registers and mask, and checks each readback and
// the ack timing of every access.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_vector_lanes
	import lane_pkg::*;
	import bus_pkg::*;
();

	localparam int NUM_LANES    = 4;
	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int ACK_LATENCY  = 4;
	localparam int ACK_LIMIT    = 20;
	localparam int RANDOM_STEPS = 200;
	localparam int PLANNED_ACCESSES = 16 * NUM_LANES + (1 + NUM_LANES)
		+ (9 + 10 * (1 + NUM_LANES)) + (6 + 2 * NUM_LANES) + RANDOM_STEPS;

	logic		clock;
	logic		reset;
	wb_req_t	wb_req;
	logic		ack;
	wb_dat_t	dat_r;

	int				errors = 0;
	int				checks = 0;
	logic			cur_is_read = 1'b0;
	logic [31:0]	lfsr_state = 32'h99f67c10;
	data_t			exp_q [$];
	string			name_q [$];

	// Model of the lanes
	data_t	model_regs [NUM_LANES][16];
	logic	model_mask [NUM_LANES];

	vector_lanes_top #(
		.NUM_LANES	(NUM_LANES)
	) uut (
		.clock		(clock),
		.reset		(reset),
		.wb_req		(wb_req),
		.ack		(ack),
		.dat_r		(dat_r)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	//////////////////////////////////////////////////
	// Random bits and reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic writes_register(input lane_op_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI, OP_LID};
	endfunction

	function automatic data_t expected_value(input lane_op_e op, input data_t a,
		input data_t b, input logic [15:0] imm, input int lane);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_LDI:  return {16'h0, imm};
			OP_LID:  return {16'h0, imm} + data_t'(lane);
			default: return a;
		endcase
	endfunction

	// Applies one broadcast command to every modelled lane
	function automatic void model_command(input lane_op_e op, input reg_idx_t dst,
		input reg_idx_t s1, input reg_idx_t s2, input logic [15:0] imm);
		data_t a;
		data_t b;
		for (int l = 0; l < NUM_LANES; l++) begin
			a = model_regs[l][s1];
			b = model_regs[l][s2];
			if (writes_register(op) && model_mask[l]) begin
				model_regs[l][dst] = expected_value(op, a, b, imm, l);
			end
			if (op == OP_SETM) begin
				model_mask[l] = (a < b);
			end else if (op == OP_CLRM) begin
				model_mask[l] = 1'b1;
			end
		end
	endfunction

	//////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////

	task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
		input string tname);
		int edges;
		cur_is_read  = !we;
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = we;
		wb_req.adr   = adr;
		wb_req.dat_w = dat;
		edges = 0;
		do begin
			@(posedge clock);
			#DRIVE_DELAY;
			edges++;
		end while (ack !== 1'b1 && edges < ACK_LIMIT);
		checks++;
		if (ack !== 1'b1) begin
			$display("%s: no ack within %0d cycles", tname, ACK_LIMIT);
			errors++;
			exp_q.delete();
			name_q.delete();
		end else if (edges != ACK_LATENCY) begin
			$display("ERR %s ack latency expected %0d actual %0d", tname, ACK_LATENCY, edges);
			errors++;
		end
		// Strobe stays up through the ack edge and drops in the next cycle
		@(posedge clock);
		#DRIVE_DELAY;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		checks++;
		if (ack !== 1'b0) begin
			$display("%s: ack stayed high for more than one cycle", tname);
			errors++;
		end
	endtask

	task automatic send_command(input lane_op_e op, input reg_idx_t dst, input reg_idx_t s1,
		input reg_idx_t s2, input logic [15:0] imm, input string tname);
		cmd_word_t word;
		word.op   = op;
		word.dst  = dst;
		word.src1 = s1;
		word.src2 = s2;
		word.imm  = imm;
		model_command(op, dst, s1, s2, imm);
		bus_access(1'b1, ADR_CMD, word, tname);
	endtask

	// Lane field wraps onto the lanes that exist
	task automatic read_reg(input logic [3:0] lane_f, input reg_idx_t idx, input string tname);
		exp_q.push_back(model_regs[int'(lane_f) % NUM_LANES][idx]);
		name_q.push_back(tname);
		bus_access(1'b0, ADR_REG_BASE | {4'h0, lane_f, idx}, '0, tname);
	endtask

	task automatic read_all_lanes(input reg_idx_t idx, input string tname);
		for (int l = 0; l < NUM_LANES; l++) begin
			read_reg(4'(l), idx, tname);
		end
	endtask

	// Readback data is compared on the ack edge
	always @(posedge clock) begin : compare_reads
		data_t	exp_v;
		string	name_v;
		if (ack === 1'b1 && cur_is_read) begin
			checks++;
			if (exp_q.size() == 0) begin
				$display("Read acked with no expected value waiting");
				errors++;
			end else begin
				exp_v  = exp_q.pop_front();
				name_v = name_q.pop_front();
				if (dat_r !== exp_v) begin
					$display("ERR %s expected %h actual %h", name_v, exp_v, dat_r);
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		#((PLANNED_ACCESSES * ACK_LIMIT + 40) * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("Done: errors found");
		$finish;
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0]	rnd;
		reg_idx_t		s1;
		reg_idx_t		s2;
		reg_idx_t		dst;
		lane_op_e		op;
		lane_op_e		alu_ops [5];
		string			alu_name;
		clock  = 1'b0;
		reset  = 1'b1;
		wb_req = '0;
		alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
		for (int l = 0; l < NUM_LANES; l++) begin
			model_mask[l] = 1'b1;
			for (int r = 0; r < 16; r++) begin
				model_regs[l][r] = '0;
			end
		end
		repeat (8) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;

		// Idle bus after reset
		repeat (10) begin
			@(posedge clock);
			#DRIVE_DELAY;
			checks++;
			if (ack !== 1'b0) begin
				$display("ack high with no access after reset");
				errors++;
			end
		end
		for (int r = 0; r < 16; r++) begin
			read_all_lanes(reg_idx_t'(r), "reset_regs");
		end

		// Lane identity
		take_bits(16, rnd);
		send_command(OP_LID, 4'd3, 4'd0, 4'd0, rnd[15:0], "lane_id");
		read_all_lanes(4'd3, "lane_id");

		// ALU ops with sources in the same bank and in opposite banks
		for (int r = 0; r < 8; r++) begin
			take_bits(16, rnd);
			send_command(OP_LDI, reg_idx_t'(r), 4'd0, 4'd0, rnd[15:0], "alu_load");
		end
		take_bits(16, rnd);
		send_command(OP_LID, 4'd7, 4'd0, 4'd0, rnd[15:0], "alu_load");
		for (int i = 0; i < 5; i++) begin
			for (int same = 0; same < 2; same++) begin
				take_bits(9, rnd);
				s1  = {1'b0, rnd[2:0]};
				s2  = {1'b0, rnd[5:4], (same == 1) ? rnd[0] : ~rnd[0]};
				dst = {1'b1, rnd[8:6]};
				alu_name = $sformatf("alu_%s", alu_ops[i].name());
				send_command(alu_ops[i], dst, s1, s2, 16'h0, alu_name);
				read_all_lanes(dst, alu_name);
			end
		end

		// Mask on for lanes 0 and 1 only and cleared afterwards
		send_command(OP_LID, 4'd2, 4'd0, 4'd0, 16'h0, "mask_setup");
		send_command(OP_LDI, 4'd4, 4'd0, 4'd0, 16'd2, "mask_setup");
		send_command(OP_SETM, 4'd0, 4'd2, 4'd4, 16'h0, "mask_set");
		send_command(OP_ADD, 4'd5, 4'd2, 4'd4, 16'h0, "mask_add");
		read_all_lanes(4'd5, "mask_add");
		send_command(OP_CLRM, 4'd0, 4'd0, 4'd0, 16'h0, "mask_clear");
		send_command(OP_ADD, 4'd5, 4'd2, 4'd2, 16'h0, "unmask_add");
		read_all_lanes(4'd5, "unmask_add");

		// Random mix of commands and reads
		for (int n = 0; n < RANDOM_STEPS; n++) begin
			take_bits(1, rnd);
			if (rnd[0]) begin
				take_bits(8, rnd);
				read_reg(rnd[7:4], rnd[3:0], "random_read");
			end else begin
				take_bits(4, rnd);
				op = lane_op_e'(4'(int'(rnd[3:0]) % 10));
				take_bits(28, rnd);
				send_command(op, rnd[27:24], rnd[23:20], rnd[19:16], rnd[15:0], "random_cmd");
			end
		end

		if (exp_q.size() != 0) begin
			$display("%0d reads were never acked", exp_q.size());
			errors++;
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- project.f
hdl/lane_pkg.sv
hdl/bus_pkg.sv
hdl/command_issue.sv
hdl/lane_regfile.sv
hdl/lane_unit.sv
hdl/commit_collect.sv
hdl/vector_lanes_top.sv
tests/tb_vector_lanes.sv

//--- Makefile
# Verilator build and run for the vector lane array

VERILATOR ?= verilator
TOP       ?= tb_vector_lanes
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
